// ==== hdl/pru_cmd_if.sv ====
`timescale 1ns/1ps

// one draw command from the register block to the engine
interface pru_cmd_if;
    logic [8:0]      row;
    logic [9:0]      col;
    logic [9:0]      width;
    logic [8:0]      height_radius;  // height for rect, radius for circle
    pru_pkg::shape_e shape;
    pru_pkg::pixel_t color;
    logic            subtract;
    logic            start;          // one cycle, fields valid with it
    logic            busy;

    modport regs (
        output row, col, width, height_radius,
        output shape, color, subtract, start,
        input  busy
    );

    modport engine (
        input  row, col, width, height_radius,
        input  shape, color, subtract, start,
        output busy
    );

endinterface

// ==== hdl/pru_cmd_regs.sv ====
`timescale 1ns/1ps

module pru_cmd_regs #(
    parameter logic [31:0] reg_base = 32'h0001_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_data,
    input  logic        bus_write,
    output logic        bus_ack,
    output logic        in_idle,
    output logic        in_load_2,
    pru_cmd_if.regs     cmd
);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_load_1 = 2'd1;
    localparam logic [1:0] st_load_2 = 2'd2;

    logic [1:0]         state;
    logic [31:0]        offset;
    logic               in_window;
    logic               cmd_stall;
    logic               accept;
    logic               load_pos;
    logic               load_size;
    logic               load_cmd;
    pru_pkg::bus_word_u word;

    assign word   = bus_data;
    assign offset = bus_addr - reg_base;  // wraps high below the base
    assign in_window = offset < 32'd12;

    // command writes wait until the engine is free
    assign cmd_stall = (offset == pru_pkg::reg_cmd) && cmd.busy;

    // ack high blocks a second accept of the same held write
    assign accept = bus_write && in_window && !cmd_stall && !bus_ack;

    assign load_pos  = accept && (state == st_idle)   && (offset == pru_pkg::reg_pos);
    assign load_size = accept && (state == st_load_1) && (offset == pru_pkg::reg_size);
    assign load_cmd  = accept && (state == st_load_2) && (offset == pru_pkg::reg_cmd);

    assign in_idle   = (state == st_idle);
    assign in_load_2 = (state == st_load_2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            bus_ack   <= 1'b0;
            cmd.start <= 1'b0;
        end else begin
            bus_ack   <= accept;    // wrong-register writes are acked too
            cmd.start <= load_cmd;  // same cycle as the ack
            if (load_pos) begin
                state <= st_load_1;
            end else if (load_size) begin
                state <= st_load_2;
            end else if (load_cmd) begin
                state <= st_idle;
            end
        end
    end

    // command fields
    always_ff @(posedge clk) begin
        if (load_pos) begin
            cmd.row <= word.pos.row;
            cmd.col <= word.pos.col;
        end
        if (load_size) begin
            cmd.width         <= word.size.width;
            cmd.height_radius <= word.size.height_radius;
        end
        if (load_cmd) begin
            cmd.shape    <= word.cmd.shape;
            cmd.color    <= word.cmd.color;
            cmd.subtract <= word.cmd.subtract;
        end
    end

endmodule

// ==== hdl/pru_draw_engine.sv ====
`timescale 1ns/1ps

module pru_draw_engine #(
    parameter int frame_width  = 640,
    parameter int frame_height = 480
) (
    input  logic            clk,
    input  logic            rst_n,
    pru_cmd_if.engine       cmd,
    output logic            wr_en,
    output logic [18:0]     wr_addr,
    output pru_pkg::pixel_t wr_pixel,
    output logic            pru_done
);

    localparam logic [1:0] e_idle   = 2'd0;
    localparam logic [1:0] e_walk   = 2'd1;
    localparam logic [1:0] e_finish = 2'd2;  // nothing to draw

    logic [1:0]         state;
    logic signed [12:0] row_s;
    logic signed [12:0] col_s;
    logic signed [12:0] hr_s;
    logic signed [12:0] wid_s;
    logic signed [12:0] r_lo_n;
    logic signed [12:0] r_hi_n;
    logic signed [12:0] c_lo_n;
    logic signed [12:0] c_hi_n;
    logic               box_ok;

    // latched command
    logic signed [12:0] r_hi;
    logic signed [12:0] c_lo;
    logic signed [12:0] c_hi;
    logic signed [12:0] ctr_r;
    logic signed [12:0] ctr_c;
    logic signed [25:0] rad_sq;
    pru_pkg::shape_e    shape_q;
    pru_pkg::pixel_t    color_q;
    logic               sub_q;

    logic signed [12:0] cur_r;
    logic signed [12:0] cur_c;
    logic signed [12:0] dr;
    logic signed [12:0] dc;
    logic signed [25:0] dr_sq;
    logic signed [25:0] dc_sq;
    logic               in_frame;
    logic               in_shape;
    logic               last;
    logic [18:0]        row_ext;
    logic [18:0]        col_ext;

    assign row_s = 13'(cmd.row);
    assign col_s = 13'(cmd.col);
    assign hr_s  = 13'(cmd.height_radius);
    assign wid_s = 13'(cmd.width);

    // bounding box of the incoming command
    always_comb begin
        if (cmd.shape == pru_pkg::shape_circle) begin
            r_lo_n = row_s - hr_s;
            r_hi_n = row_s + hr_s;
            c_lo_n = col_s - hr_s;
            c_hi_n = col_s + hr_s;
        end else begin
            r_lo_n = row_s;
            r_hi_n = row_s + hr_s - 13'sd1;
            c_lo_n = col_s;
            c_hi_n = col_s + wid_s - 13'sd1;
        end
    end

    assign box_ok = (cmd.shape == pru_pkg::shape_circle)
                 || (cmd.shape == pru_pkg::shape_rect && cmd.width != '0
                     && cmd.height_radius != '0);

    assign cmd.busy = (state != e_idle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= e_idle;
            pru_done <= 1'b0;
        end else begin
            pru_done <= 1'b0;
            case (state)
                e_idle: begin
                    if (cmd.start) begin
                        state <= box_ok ? e_walk : e_finish;
                    end
                end
                e_walk: begin
                    if (last) begin
                        state    <= e_idle;
                        pru_done <= 1'b1;
                    end
                end
                e_finish: begin
                    state    <= e_idle;
                    pru_done <= 1'b1;
                end
                default: state <= e_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == e_idle && cmd.start) begin
            r_hi    <= r_hi_n;
            c_lo    <= c_lo_n;
            c_hi    <= c_hi_n;
            cur_r   <= r_lo_n;
            cur_c   <= c_lo_n;
            ctr_r   <= row_s;
            ctr_c   <= col_s;
            rad_sq  <= hr_s * hr_s;
            shape_q <= cmd.shape;
            color_q <= cmd.color;
            sub_q   <= cmd.subtract;
        end else if (state == e_walk) begin
            if (cur_c == c_hi) begin  // row-major walk
                cur_c <= c_lo;
                cur_r <= cur_r + 13'sd1;
            end else begin
                cur_c <= cur_c + 13'sd1;
            end
        end
    end

    assign last = (cur_r == r_hi) && (cur_c == c_hi);

    assign dr    = cur_r - ctr_r;
    assign dc    = cur_c - ctr_c;
    assign dr_sq = dr * dr;
    assign dc_sq = dc * dc;

    assign in_frame = (cur_r >= 0) && (cur_r < frame_height)
                   && (cur_c >= 0) && (cur_c < frame_width);  // clip, no wrap
    assign in_shape = (shape_q == pru_pkg::shape_rect) || ((dr_sq + dc_sq) <= rad_sq);

    assign row_ext  = {6'd0, cur_r};
    assign col_ext  = {6'd0, cur_c};
    assign wr_addr  = row_ext * 19'(frame_width) + col_ext;
    assign wr_en    = (state == e_walk) && in_frame && in_shape;
    assign wr_pixel = sub_q ? 2'd0 : color_q;  // erase writes background

endmodule

// ==== hdl/pru_frame_buffer.sv ====
`timescale 1ns/1ps

module pru_frame_buffer #(
    parameter int frame_width  = 640,
    parameter int frame_height = 480
) (
    input  logic            clk,
    input  logic            wr_en,
    input  logic [18:0]     wr_addr,
    input  pru_pkg::pixel_t wr_pixel,
    input  logic            vga_ctrl_clk,
    input  logic [18:0]     rd_addr,
    output pru_pkg::pixel_t rd_pixel
);

    localparam int depth = frame_width * frame_height;

    pru_pkg::pixel_t mem [depth];

    // draw side
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // video side, registered read
    always_ff @(posedge vga_ctrl_clk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

// ==== hdl/pru_pkg.sv ====
package pru_pkg;

    typedef logic [1:0] pixel_t;  // 0 is background

    // codes 2 and 3 are reserved and draw nothing
    typedef enum logic [1:0] {
        shape_rect   = 2'd0,
        shape_circle = 2'd1
    } shape_e;

    typedef struct packed {
        logic [9:0] red;
        logic [9:0] green;
        logic [9:0] blue;
    } rgb_t;

    // one bus data word, read as position, size or command
    typedef union packed {
        struct packed {
            logic [12:0] rsvd;
            logic [8:0]  row;
            logic [9:0]  col;
        } pos;
        struct packed {
            logic [12:0] rsvd;
            logic [9:0]  width;
            logic [8:0]  height_radius;
        } size;
        struct packed {
            logic [26:0] rsvd;
            shape_e      shape;
            pixel_t      color;
            logic        subtract;
        } cmd;
    } bus_word_u;

    // byte offsets inside the register window
    localparam logic [31:0] reg_pos  = 32'd0;
    localparam logic [31:0] reg_size = 32'd4;
    localparam logic [31:0] reg_cmd  = 32'd8;

    function automatic rgb_t palette(input pixel_t idx);
        rgb_t c;
        case (idx)
            2'd0:    c = '{red: 10'h000, green: 10'h000, blue: 10'h000};
            2'd1:    c = '{red: 10'h3ff, green: 10'h000, blue: 10'h000};
            2'd2:    c = '{red: 10'h000, green: 10'h3ff, blue: 10'h000};
            default: c = '{red: 10'h3ff, green: 10'h3ff, blue: 10'h3ff};
        endcase
        return c;
    endfunction

endpackage

// ==== hdl/pru_scan_out.sv ====
`timescale 1ns/1ps

module pru_scan_out #(
    parameter int frame_width  = 640,
    parameter int frame_height = 480
) (
    input  logic            vga_ctrl_clk,
    input  logic            rst_n,
    input  logic            vga_read,
    output logic [18:0]     rd_addr,
    input  pru_pkg::pixel_t rd_pixel,
    output logic [9:0]      vga_red,
    output logic [9:0]      vga_green,
    output logic [9:0]      vga_blue
);

    localparam logic [18:0] last_addr = 19'(frame_width * frame_height - 1);

    pru_pkg::rgb_t rgb;

    // raster counter, rst_n sampled on the video clock
    always_ff @(posedge vga_ctrl_clk) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (vga_read) begin
            if (rd_addr == last_addr) begin
                rd_addr <= '0;  // wrap to top-left
            end else begin
                rd_addr <= rd_addr + 19'd1;
            end
        end
    end

    // frame buffer output goes straight through the palette
    assign rgb = pru_pkg::palette(rd_pixel);

    assign vga_red   = rgb.red;
    assign vga_green = rgb.green;
    assign vga_blue  = rgb.blue;

endmodule

// ==== hdl/pru_top.sv ====
`timescale 1ns/1ps

module pru_top #(
    parameter int          frame_width  = 640,
    parameter int          frame_height = 480,
    parameter logic [31:0] reg_base     = 32'h0001_0000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        vga_ctrl_clk,
    input  logic        vga_read,
    input  logic [31:0] bus_addr,
    input  logic [31:0] bus_data,
    input  logic        bus_write,
    output logic        bus_ack,
    output logic [9:0]  vga_red,
    output logic [9:0]  vga_green,
    output logic [9:0]  vga_blue,
    output logic        pru_start,
    output logic        pru_done,
    output logic        in_idle,
    output logic        in_load_2
);

    logic            wr_en;
    logic [18:0]     wr_addr;
    pru_pkg::pixel_t wr_pixel;
    logic [18:0]     rd_addr;
    pru_pkg::pixel_t rd_pixel;

    pru_cmd_if u_cmd_if ();

    assign pru_start = u_cmd_if.start;  // exposed for the testbench

    pru_cmd_regs #(
        .reg_base (reg_base)
    ) u_cmd_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_addr  (bus_addr),
        .bus_data  (bus_data),
        .bus_write (bus_write),
        .bus_ack   (bus_ack),
        .in_idle   (in_idle),
        .in_load_2 (in_load_2),
        .cmd       (u_cmd_if.regs)
    );

    pru_draw_engine #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) u_draw_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (u_cmd_if.engine),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .pru_done (pru_done)
    );

    pru_frame_buffer #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) u_frame_buffer (
        .clk          (clk),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_pixel     (wr_pixel),
        .vga_ctrl_clk (vga_ctrl_clk),
        .rd_addr      (rd_addr),
        .rd_pixel     (rd_pixel)
    );

    pru_scan_out #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) u_scan_out (
        .vga_ctrl_clk (vga_ctrl_clk),
        .rst_n        (rst_n),
        .vga_read     (vga_read),
        .rd_addr      (rd_addr),
        .rd_pixel     (rd_pixel),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

endmodule

// ==== project.f ====
+incdir+tb
hdl/pru_pkg.sv
hdl/pru_cmd_if.sv
hdl/pru_cmd_regs.sv
hdl/pru_draw_engine.sv
hdl/pru_frame_buffer.sv
hdl/pru_scan_out.sv
hdl/pru_top.sv
tb/tb_pru_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f project.f --top-module tb_pru_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pru_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF "Finished with no errors" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb/pru_tb_model.svh ====
`ifndef PRU_TB_MODEL_SVH
`define PRU_TB_MODEL_SVH

typedef struct {
    int              row;
    int              col;
    int              width;
    int              hr;        // height for rect, radius for circle
    logic [1:0]      shape;     // 0 rect, 1 circle, 2 and 3 reserved
    pru_pkg::pixel_t color;
    bit              subtract;
} draw_cmd_t;

pru_pkg::pixel_t shadow [fw * fh];  // expected frame contents
int              check_count = 0;
int              err_count = 0;

// does command c paint pixel (r, col)
function automatic bit covers(input draw_cmd_t c, input int r, input int col);
    int dr;
    int dc;
    dr = r - c.row;
    dc = col - c.col;
    if (r < 0 || r >= fh || col < 0 || col >= fw) begin
        return 1'b0;  // off screen, skipped
    end
    case (c.shape)
        2'd0:    return dr >= 0 && dr < c.hr && dc >= 0 && dc < c.width;
        2'd1:    return dr * dr + dc * dc <= c.hr * c.hr;
        default: return 1'b0;
    endcase
endfunction

task automatic apply_command(input draw_cmd_t c);
    for (int r = c.row - c.hr; r <= c.row + c.hr; r++) begin
        for (int col = c.col - c.hr; col <= c.col + c.width + c.hr; col++) begin
            if (covers(c, r, col)) begin
                shadow[r * fw + col] = c.subtract ? 2'd0 : c.color;
            end
        end
    end
endtask

// cells the engine walks for one command
function automatic longint box_area(input draw_cmd_t c);
    case (c.shape)
        2'd0:    return longint'(c.width) * c.hr;
        2'd1:    return longint'(2 * c.hr + 1) * (2 * c.hr + 1);
        default: return 0;
    endcase
endfunction

// black, red, green, white
function automatic pru_pkg::rgb_t expected_rgb(input pru_pkg::pixel_t p);
    pru_pkg::rgb_t c;
    c.red   = (p == 2'd1 || p == 2'd3) ? 10'h3ff : 10'h000;
    c.green = (p == 2'd2 || p == 2'd3) ? 10'h3ff : 10'h000;
    c.blue  = (p == 2'd3) ? 10'h3ff : 10'h000;
    return c;
endfunction

task automatic check_rgb(input pru_pkg::rgb_t got, input pru_pkg::rgb_t exp, input int addr);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERR t=%0t vga_red/vga_green/vga_blue pixel %0d got %h/%h/%h exp %h/%h/%h",
                 $time, addr, got.red, got.green, got.blue, exp.red, exp.green, exp.blue);
    end
endtask

// bit order is {in_idle, in_load_2, bus_ack, pru_start, pru_done}
task automatic check_flags(input logic [4:0] got, input logic [4:0] exp, input string where);
    string names [5] = '{"pru_done", "pru_start", "bus_ack", "in_load_2", "in_idle"};
    check_count++;
    if (got !== exp) begin
        err_count++;
    end
    for (int i = 0; i < 5; i++) begin
        if (got[i] !== exp[i]) begin
            $display("ERR t=%0t %s (%s) got %b exp %b", $time, names[i], where, got[i], exp[i]);
        end
    end
endtask

task automatic report_failure(input string what);
    err_count++;
    $display("t=%0t %s", $time, what);
endtask

`endif

// ==== tb/tb_pru_top.sv ====
`timescale 1ns/1ps

module tb_pru_top;

    localparam int          fw     = 640;
    localparam int          fh     = 480;
    localparam int          pixels = fw * fh;
    localparam logic [31:0] base   = 32'h0001_0000;

    logic        clk = 1'b0;
    logic        vga_ctrl_clk = 1'b0;
    logic        rst_n;
    logic        vga_read = 1'b0;  // owned by the scan process
    logic [31:0] bus_addr;
    logic [31:0] bus_data;
    logic        bus_write;
    logic        bus_ack;
    logic [9:0]  vga_red;
    logic [9:0]  vga_green;
    logic [9:0]  vga_blue;
    logic        pru_start;
    logic        pru_done;
    logic        in_idle;
    logic        in_load_2;

    `include "pru_tb_model.svh"

    draw_cmd_t  cmds [$];
    integer     seed = 32'h6102_5a73;
    longint     cycles = 0;
    longint     cycle_limit = 64'd1_000_000_000;
    logic [4:0] ack_flags;  // status seen with the last ack
    int         start_count = 0;
    int         done_count = 0;
    int         scans_req = 0;
    int         scans_done = 0;
    int         scan_idx = 0;
    logic       cmp_pending = 1'b0;

    pru_top #(
        .frame_width  (fw),
        .frame_height (fh),
        .reg_base     (base)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .vga_ctrl_clk (vga_ctrl_clk),
        .vga_read     (vga_read),
        .bus_addr     (bus_addr),
        .bus_data     (bus_data),
        .bus_write    (bus_write),
        .bus_ack      (bus_ack),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue),
        .pru_start    (pru_start),
        .pru_done     (pru_done),
        .in_idle      (in_idle),
        .in_load_2    (in_load_2)
    );

    always #20 clk = ~clk;
    always #10 vga_ctrl_clk = ~vga_ctrl_clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d clk cycles, the DUT stopped responding", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // pulse counters
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (pru_start) start_count++;
            if (pru_done) done_count++;
        end
    end

    // scan-out compare, one pixel per video cycle
    always @(posedge vga_ctrl_clk) cmp_pending <= vga_read;

    always @(negedge vga_ctrl_clk) begin
        if (cmp_pending) begin
            check_rgb({vga_red, vga_green, vga_blue}, expected_rgb(shadow[scan_idx]), scan_idx);
            scan_idx++;
            if (scan_idx == pixels) begin
                vga_read = 1'b0;  // counter has wrapped back to 0
                scans_done++;
            end
        end else if (!vga_read && scans_done < scans_req) begin
            scan_idx = 0;
            vga_read = 1'b1;
        end
    end

    function automatic logic [4:0] flags_now();
        return {in_idle, in_load_2, bus_ack, pru_start, pru_done};
    endfunction

    function automatic draw_cmd_t make_cmd(input int row, input int col, input int width,
                                           input int hr, input logic [1:0] shape,
                                           input pru_pkg::pixel_t color, input bit sub);
        draw_cmd_t c;
        c.row      = row;
        c.col      = col;
        c.width    = width;
        c.hr       = hr;
        c.shape    = shape;
        c.color    = color;
        c.subtract = sub;
        return c;
    endfunction

    function automatic draw_cmd_t random_cmd();
        draw_cmd_t c;
        c.shape    = 2'($unsigned($random(seed)) % 2);
        c.row      = $unsigned($random(seed)) % 500;  // may run past the bottom
        c.col      = $unsigned($random(seed)) % 660;
        c.width    = 1 + $unsigned($random(seed)) % 80;
        c.hr       = (c.shape == 2'd1) ? $unsigned($random(seed)) % 41
                                       : 1 + $unsigned($random(seed)) % 60;
        c.color    = 2'($unsigned($random(seed)) % 4);
        c.subtract = ($unsigned($random(seed)) % 4) == 0;
        return c;
    endfunction

    task automatic build_commands();
        longint area;
        area = 0;
        cmds.push_back(make_cmd(2, 3, 6, 4, 2'd0, 2'd2, 1'b0));
        cmds.push_back(make_cmd(0, 0, fw, fh, 2'd0, 2'd0, 1'b1));   // clear the frame
        cmds.push_back(make_cmd(20, 30, 50, 25, 2'd0, 2'd3, 1'b0));
        cmds.push_back(make_cmd(5, 8, 0, 12, 2'd1, 2'd1, 1'b0));    // clipped at top-left
        cmds.push_back(make_cmd(25, 40, 20, 10, 2'd0, 2'd1, 1'b1));
        cmds.push_back(make_cmd(60, 60, 10, 10, 2'd2, 2'd3, 1'b0));
        for (int i = 0; i < 12; i++) begin
            cmds.push_back(random_cmd());
        end
        cmds.push_back(make_cmd(100, 100, 100, 50, 2'd0, 2'd2, 1'b0));  // long busy period
        cmds.push_back(make_cmd(300, 300, 0, 9, 2'd1, 2'd3, 1'b0));
        cmds.push_back(make_cmd(0, 0, 4, 4, 2'd3, 2'd1, 1'b0));
        foreach (cmds[i]) area += box_area(cmds[i]);
        cycle_limit = 2 * area + 2 * pixels + 1000;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_addr  = addr;
        bus_data  = data;
        bus_write = 1'b1;
        @(negedge clk);
        while (!bus_ack) begin
            @(negedge clk);
        end
        ack_flags = flags_now();
        bus_write = 1'b0;
    endtask

    task automatic write_pos(input draw_cmd_t c);
        pru_pkg::bus_word_u w;
        w = '0;
        w.pos.row = c.row[8:0];
        w.pos.col = c.col[9:0];
        write_reg(base + pru_pkg::reg_pos, w);
    endtask

    task automatic write_size(input draw_cmd_t c);
        pru_pkg::bus_word_u w;
        w = '0;
        w.size.width         = c.width[9:0];
        w.size.height_radius = c.hr[8:0];
        write_reg(base + pru_pkg::reg_size, w);
    endtask

    task automatic write_cmd(input draw_cmd_t c);
        pru_pkg::bus_word_u w;
        w = '0;
        w.cmd.shape    = pru_pkg::shape_e'(c.shape);
        w.cmd.color    = c.color;
        w.cmd.subtract = c.subtract;
        write_reg(base + pru_pkg::reg_cmd, w);
    endtask

    task automatic stray_write(input logic [31:0] addr);
        bit acked;
        acked = 1'b0;
        @(negedge clk);
        bus_addr  = addr;
        bus_data  = 32'h0000_0155;
        bus_write = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (bus_ack) acked = 1'b1;
        end
        bus_write = 1'b0;
        if (acked) report_failure($sformatf("write to %h outside the window was acked", addr));
    endtask

    // wait for pru_done, then update the shadow frame
    task automatic finish_command(input draw_cmd_t c, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!pru_done);
        apply_command(c);
    endtask

    task automatic draw(input draw_cmd_t c);
        int waited;
        write_pos(c);
        write_size(c);
        write_cmd(c);
        finish_command(c, waited);
    endtask

    task automatic run_scan();
        scans_req++;
        wait (scans_done == scans_req);
    endtask

    task automatic test_line(input int n, input string name, input int err0);
        $display("test %0d %s: %0d errors", n, name, err_count - err0);
    endtask

    initial begin
        draw_cmd_t c;
        draw_cmd_t c2;
        int        waited;
        int        s0;
        int        d0;
        int        err0;
        rst_n     = 1'b0;
        bus_addr  = '0;
        bus_data  = '0;
        bus_write = 1'b0;
        build_commands();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err0 = err_count;
        check_flags(flags_now(), 5'b10000, "after reset");
        c = cmds.pop_front();
        write_pos(c);
        check_flags(ack_flags, 5'b00100, "position write");
        write_size(c);
        check_flags(ack_flags, 5'b01100, "size write");
        s0 = start_count;
        d0 = done_count;
        write_cmd(c);
        check_flags(ack_flags, 5'b10110, "command write");  // start rides with the ack
        finish_command(c, waited);
        repeat (4) @(negedge clk);
        if (start_count - s0 != 1) report_failure("pru_start did not pulse exactly once");
        if (done_count - d0 != 1) report_failure("pru_done did not pulse exactly once");
        check_flags(flags_now(), 5'b10000, "after done");
        test_line(1, "reset and load sequence", err0);

        err0 = err_count;
        repeat (3) draw(cmds.pop_front());
        run_scan();
        test_line(2, "rectangle and clipped circle", err0);

        err0 = err_count;
        draw(cmds.pop_front());
        c = cmds.pop_front();
        write_pos(c);
        write_size(c);
        write_cmd(c);
        finish_command(c, waited);
        if (waited != 2) report_failure("reserved shape did not give pru_done two cycles later");
        run_scan();
        test_line(3, "erase and reserved shape", err0);

        err0 = err_count;
        repeat (12) draw(cmds.pop_front());
        run_scan();
        test_line(4, "random shapes", err0);

        err0 = err_count;
        c  = cmds.pop_front();
        c2 = cmds.pop_front();
        write_pos(c);
        write_size(c);
        write_cmd(c);
        d0 = done_count;
        write_pos(c2);  // register loads go on while the engine draws
        write_size(c2);
        write_cmd(c2);
        if (done_count == d0) report_failure("command write was acked while the engine was busy");
        apply_command(c);
        finish_command(c2, waited);
        c = cmds.pop_front();
        write_pos(c);
        check_flags(ack_flags, 5'b00100, "position write before stray writes");
        stray_write(base + 32'h40);
        stray_write(base - 32'd4);
        check_flags(flags_now(), 5'b00000, "after stray writes");
        write_size(c);
        write_cmd(c);
        finish_command(c, waited);
        test_line(5, "busy stall and stray writes", err0);

        repeat (4) @(negedge clk);
        $display("tests 5, checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
